// ==== serial_defines.svh ====
`ifndef SERIAL_DEFINES_SVH
`define SERIAL_DEFINES_SVH

// operand and result width, one bit is processed per clock
`define SERIAL_XLEN 32

// bit counter width, enough to index every bit of a word
`define SERIAL_CNT_W 5

`endif

// ==== serial_ctrl_pkg.sv ====
package serial_ctrl_pkg;

   // operations supported by the serial unit
   // everything except add runs the adder as a subtractor
   typedef enum logic [2:0] {
      OP_ADD  = 3'd0,
      OP_SUB  = 3'd1,
      OP_SLT  = 3'd2,
      OP_SLTU = 3'd3,
      OP_SEQ  = 3'd4
   } op_e;

   // sequencer states
   // idle waits for a request, run walks the bits, done holds the result
   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,
      ST_RUN  = 2'd1,
      ST_DONE = 2'd2
   } state_e;

endpackage

// ==== serial_data_pkg.sv ====
package serial_data_pkg;

   `include "serial_defines.svh"

   // one operand or result word
   typedef logic [`SERIAL_XLEN-1:0] word_t;

   // index of the bit currently on the serial datapath
   typedef logic [`SERIAL_CNT_W-1:0] cnt_t;

   // counter value of the msb, where the word is complete
   localparam cnt_t CNT_LAST = cnt_t'(`SERIAL_XLEN - 1);

endpackage

// ==== serial_state.sv ====
module serial_state (
   input  logic i_clk,
   input  logic i_rst,
   // request side
   input  logic i_valid,
   output logic o_ready,
   // response side
   input  logic i_ready,
   output logic o_valid,
   // phase strobes to the datapath
   output logic o_load,
   output logic o_cnt_en,
   output logic o_cnt0,
   output logic o_cnt_last
);

   import serial_ctrl_pkg::*;
   import serial_data_pkg::*;

   state_e state_q;
   state_e state_d;
   cnt_t   cnt_q;

   // accept only when no transaction is in flight
   assign o_ready = (state_q == ST_IDLE);
   assign o_valid = (state_q == ST_DONE);

   // accept strobe, operands are captured on this edge
   assign o_load = i_valid & o_ready;

   // counter runs only in run, so the strobes are qualified by it
   assign o_cnt_en   = (state_q == ST_RUN);
   assign o_cnt0     = o_cnt_en & (cnt_q == '0);
   assign o_cnt_last = o_cnt_en & (cnt_q == CNT_LAST);

   // next state
   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (o_load) begin
               state_d = ST_RUN;
            end
         end
         ST_RUN: begin
            // msb is processed this cycle, result is captured on the edge
            if (o_cnt_last) begin
               state_d = ST_DONE;
            end
         end
         ST_DONE: begin
            // hold the result until the sink takes it
            if (i_ready) begin
               state_d = ST_IDLE;
            end
         end
         default: begin
            state_d = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state_q <= ST_IDLE;
         cnt_q   <= '0;
      end else begin
         state_q <= state_d;
         // restart at bit 0 on accept
         if (o_load) begin
            cnt_q <= '0;
         end else if (o_cnt_en && !o_cnt_last) begin
            cnt_q <= cnt_q + cnt_t'(1);
         end
         // counter parks at the last bit until the next accept
      end
   end

endmodule

// ==== serial_opshift.sv ====
module serial_opshift (
   input  logic                   i_clk,
   input  logic                   i_load,
   input  logic                   i_cnt_en,
   input  serial_ctrl_pkg::op_e   i_op,
   input  serial_data_pkg::word_t i_a,
   input  serial_data_pkg::word_t i_b,
   output logic                   o_a_bit,
   output logic                   o_b_bit,
   output serial_ctrl_pkg::op_e   o_op
);

   import serial_ctrl_pkg::*;
   import serial_data_pkg::*;

   `include "serial_defines.svh"

   word_t a_q;
   word_t b_q;
   op_e   op_q;

   always_ff @(posedge i_clk) begin
      if (i_load) begin
         // capture the whole request on accept
         a_q  <= i_a;
         b_q  <= i_b;
         op_q <= i_op;
      end else if (i_cnt_en) begin
         // move the next bit into position 0
         a_q <= {1'b0, a_q[`SERIAL_XLEN-1:1]};
         b_q <= {1'b0, b_q[`SERIAL_XLEN-1:1]};
      end
   end

   // lsb first, bit k is on the outputs during run cycle k
   assign o_a_bit = a_q[0];
   assign o_b_bit = b_q[0];

   // opcode stays stable for the whole transaction
   assign o_op = op_q;

endmodule

// ==== serial_alu.sv ====
module serial_alu (
   input  logic                   i_clk,
   input  logic                   i_rst,
   // phase strobes from the sequencer
   input  logic                   i_cnt_en,
   input  logic                   i_cnt0,
   input  logic                   i_cnt_last,
   // serial operand bits, lsb first
   input  logic                   i_a_bit,
   input  logic                   i_b_bit,
   input  serial_ctrl_pkg::op_e   i_op,
   output serial_data_pkg::word_t o_result
);

   import serial_ctrl_pkg::*;
   import serial_data_pkg::*;

   `include "serial_defines.svh"

   logic  sub;
   logic  b_eff;
   logic  cin;
   logic  sum;
   logic  cout;
   logic  eq_now;
   logic  carry_q;
   logic  eq_q;
   logic  ovf;
   logic  cmp;
   word_t sum_q;
   word_t sum_word;

   // compares are done as a - b, so only add keeps b as is
   assign sub = (i_op != OP_ADD);

   // two's complement negate: invert b and add one on the first bit
   assign b_eff = i_b_bit ^ sub;
   assign cin   = i_cnt0 ? sub : carry_q;

   // one bit full adder
   assign sum  = i_a_bit ^ b_eff ^ cin;
   assign cout = (i_a_bit & b_eff) | (cin & (i_a_bit ^ b_eff));

   // equality so far, restarts at bit 0
   assign eq_now = (i_cnt0 | eq_q) & (i_a_bit == i_b_bit);

   // signed overflow on the msb, carry into it differs from carry out
   assign ovf = cin ^ cout;

   // full sum word including the bit of this cycle
   assign sum_word = {sum, sum_q[`SERIAL_XLEN-1:1]};

   // compare flag, only meaningful on the last bit
   always_comb begin
      case (i_op)
         // sign of the difference, corrected for overflow
         OP_SLT:  cmp = sum ^ ovf;
         // a borrow means a < b
         OP_SLTU: cmp = ~cout;
         OP_SEQ:  cmp = eq_now;
         default: cmp = 1'b0;
      endcase
   end

   // carry and equality state between bits
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         carry_q <= 1'b0;
         eq_q    <= 1'b0;
      end else if (i_cnt_en) begin
         carry_q <= cout;
         eq_q    <= eq_now;
      end
   end

   // sum bits enter at the top and move down towards bit 0
   always_ff @(posedge i_clk) begin
      if (i_cnt_en) begin
         sum_q <= sum_word;
      end
   end

   // output word, formed once on the last bit and held until the next one
   always_ff @(posedge i_clk) begin
      if (i_cnt_last) begin
         if ((i_op == OP_ADD) || (i_op == OP_SUB)) begin
            o_result <= sum_word;
         end else begin
            o_result <= {{(`SERIAL_XLEN-1){1'b0}}, cmp};
         end
      end
   end

endmodule

// ==== serial_op_unit.sv ====
module serial_op_unit (
   input  logic                   i_clk,
   input  logic                   i_rst,
   // request
   input  logic                   i_valid,
   input  serial_ctrl_pkg::op_e   i_op,
   input  serial_data_pkg::word_t i_a,
   input  serial_data_pkg::word_t i_b,
   output logic                   o_ready,
   // response
   output logic                   o_valid,
   output serial_data_pkg::word_t o_result,
   input  logic                   i_ready
);

   import serial_ctrl_pkg::*;

   logic load;
   logic cnt_en;
   logic cnt0;
   logic cnt_last;
   logic a_bit;
   logic b_bit;
   op_e  op;

   // sequencer, owns both handshakes and the bit counter
   serial_state serial_state_inst (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_valid    (i_valid),
      .o_ready    (o_ready),
      .i_ready    (i_ready),
      .o_valid    (o_valid),
      .o_load     (load),
      .o_cnt_en   (cnt_en),
      .o_cnt0     (cnt0),
      .o_cnt_last (cnt_last)
   );

   // operand shifters next to the sequencer
   serial_opshift serial_opshift_inst (
      .i_clk    (i_clk),
      .i_load   (load),
      .i_cnt_en (cnt_en),
      .i_op     (i_op),
      .i_a      (i_a),
      .i_b      (i_b),
      .o_a_bit  (a_bit),
      .o_b_bit  (b_bit),
      .o_op     (op)
   );

   // combines strobes and operand bits into the result
   serial_alu serial_alu_inst (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_cnt_en   (cnt_en),
      .i_cnt0     (cnt0),
      .i_cnt_last (cnt_last),
      .i_a_bit    (a_bit),
      .i_b_bit    (b_bit),
      .i_op       (op),
      .o_result   (o_result)
   );

endmodule

// ==== serial_op_unit_tb.sv ====
module serial_op_unit_tb;

   import serial_ctrl_pkg::*;
   import serial_data_pkg::*;

   `include "serial_defines.svh"

   localparam int          PERIOD       = 100;
   localparam int          RESET_CYCLES = 4;
   localparam int          N_FIXED      = 14;
   localparam int          N_RANDOM     = 26;
   localparam int          N_ROWS       = N_FIXED + N_RANDOM;
   // longest row is about 36 cycles plus the stall
   localparam int          MAX_STALL    = 3;
   localparam int          ROW_CYCLES   = 40;
   localparam int          LATENCY      = `SERIAL_XLEN + 1;
   localparam int unsigned SEED         = 32'h597cb944;

   logic  i_clk;
   logic  i_rst;
   logic  i_valid;
   op_e   i_op;
   word_t i_a;
   word_t i_b;
   logic  o_ready;
   logic  o_valid;
   word_t o_result;
   logic  i_ready;

   // stimulus table, one transaction per row
   op_e   tbl_op  [N_ROWS];
   word_t tbl_a   [N_ROWS];
   word_t tbl_b   [N_ROWS];
   word_t tbl_exp [N_ROWS];

   serial_op_unit serial_op_unit_inst (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_valid  (i_valid),
      .i_op     (i_op),
      .i_a      (i_a),
      .i_b      (i_b),
      .o_ready  (o_ready),
      .o_valid  (o_valid),
      .o_result (o_result),
      .i_ready  (i_ready)
   );

   initial begin
      i_clk = 1'b0;
      forever #(PERIOD / 2) i_clk = ~i_clk;
   end

   // run length bound, every row gets a fixed cycle budget
   initial begin
      #((N_ROWS * ROW_CYCLES + RESET_CYCLES + 10) * PERIOD);
      $display("timeout: the DUT did not finish all transactions in time");
      $display("Regression failed");
      $fatal(1);
   end

   task automatic check(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
         $display("Regression failed");
         $fatal(1);
      end
   endtask

   // reference behavior of each opcode on whole words
   function automatic word_t expected_result(input op_e op, input word_t a, input word_t b);
      case (op)
         OP_ADD:  return a + b;
         OP_SUB:  return a - b;
         OP_SLT:  return word_t'($signed(a) < $signed(b));
         OP_SLTU: return word_t'(a < b);
         OP_SEQ:  return word_t'(a == b);
         default: return '0;
      endcase
   endfunction

   task automatic set_row(input int idx, input op_e op, input word_t a, input word_t b,
                          input word_t exp);
      tbl_op[idx]  = op;
      tbl_a[idx]   = a;
      tbl_b[idx]   = b;
      tbl_exp[idx] = exp;
   endtask

   task automatic fill_fixed_rows();
      // carry through every bit
      set_row(0, OP_ADD, 32'hFFFFFFFF, 32'h00000001, 32'h00000000);
      set_row(1, OP_ADD, 32'h12345678, 32'h0FEDCBA9, 32'h22222221);
      set_row(2, OP_SUB, 32'h00000000, 32'h00000001, 32'hFFFFFFFF);
      set_row(3, OP_SUB, 32'h80000000, 32'h00000001, 32'h7FFFFFFF);
      // sign boundary, signed and unsigned disagree
      set_row(4, OP_SLT, 32'h80000000, 32'h00000001, 32'h00000001);
      set_row(5, OP_SLTU, 32'h80000000, 32'h00000001, 32'h00000000);
      set_row(6, OP_SLT, 32'h00000001, 32'h80000000, 32'h00000000);
      set_row(7, OP_SLTU, 32'h00000001, 32'h80000000, 32'h00000001);
      // difference overflows here
      set_row(8, OP_SLT, 32'h7FFFFFFF, 32'h80000000, 32'h00000000);
      set_row(9, OP_SLT, 32'hFFFFFFFF, 32'h00000000, 32'h00000001);
      set_row(10, OP_SEQ, 32'hA5A5A5A5, 32'hA5A5A5A5, 32'h00000001);
      // only the msb or only the lsb differs
      set_row(11, OP_SEQ, 32'h00000000, 32'h80000000, 32'h00000000);
      set_row(12, OP_SEQ, 32'h00000001, 32'h00000000, 32'h00000000);
      set_row(13, OP_SLTU, 32'h00000005, 32'h00000005, 32'h00000000);
   endtask

   task automatic fill_random_rows();
      logic [2:0] sel;
      word_t      a;
      word_t      b;
      for (int i = N_FIXED; i < N_ROWS; i++) begin
         sel = 3'($urandom % 5);
         a = $urandom;
         // equal operands now and then so seq sees both outcomes
         if (($urandom % 4) == 0) begin
            b = a;
         end else begin
            b = $urandom;
         end
         set_row(i, op_e'(sel), a, b, expected_result(op_e'(sel), a, b));
      end
   endtask

   task automatic run_row(input int idx);
      int    edges;
      int    stall;
      word_t held;
      @(posedge i_clk);
      i_valid <= 1'b1;
      i_op    <= tbl_op[idx];
      i_a     <= tbl_a[idx];
      i_b     <= tbl_b[idx];
      @(negedge i_clk);
      while (!o_ready) begin
         @(negedge i_clk);
      end
      // accepting edge, counted as the first edge of the latency
      @(posedge i_clk);
      i_valid <= 1'b0;
      edges = 1;
      @(negedge i_clk);
      while (!o_valid) begin
         check("o_ready", word_t'(o_ready), '0);
         @(posedge i_clk);
         edges++;
         @(negedge i_clk);
      end
      check("latency", word_t'(edges), word_t'(LATENCY));
      // sink stalls, the result must hold
      held = o_result;
      stall = $urandom % (MAX_STALL + 1);
      for (int s = 0; s < stall; s++) begin
         @(posedge i_clk);
         @(negedge i_clk);
         check("o_result", o_result, held);
         check("o_ready", word_t'(o_ready), '0);
         check("o_valid", word_t'(o_valid), word_t'(1));
      end
      @(posedge i_clk);
      i_ready <= 1'b1;
      @(negedge i_clk);
      check("o_result", o_result, tbl_exp[idx]);
      // consumption edge, back to idle right away
      @(posedge i_clk);
      i_ready <= 1'b0;
      @(negedge i_clk);
      check("o_valid", word_t'(o_valid), '0);
      check("o_ready", word_t'(o_ready), word_t'(1));
   endtask

   initial begin
      void'($urandom(SEED));
      i_rst   = 1'b1;
      i_valid = 1'b0;
      i_op    = OP_ADD;
      i_a     = '0;
      i_b     = '0;
      i_ready = 1'b0;
      fill_fixed_rows();
      fill_random_rows();
      repeat (RESET_CYCLES) @(posedge i_clk);
      i_rst <= 1'b0;
      @(negedge i_clk);
      check("o_ready", word_t'(o_ready), word_t'(1));
      check("o_valid", word_t'(o_valid), '0);
      for (int i = 0; i < N_ROWS; i++) begin
         run_row(i);
      end
      $display("Regression passed");
      $finish;
   end

endmodule

// ==== sources.f ====
+incdir+.
serial_ctrl_pkg.sv
serial_data_pkg.sv
serial_state.sv
serial_opshift.sv
serial_alu.sv
serial_op_unit.sv
serial_op_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the serial_op_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module serial_op_unit_tb -o serial_op_unit_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

output=$(./obj_dir/serial_op_unit_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -q "Regression passed"; then
   exit 0
fi
exit 1
